// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= coreTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== all.f ====
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/corePipePkg.sv
hdl/instrDecoder.sv
hdl/hazardControl.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/coreTop.sv
test/coreTb_sva.sv
test/coreTb.sv

// ==== hdl/corePipePkg.sv ====
/*
 * Pipeline package
 * ALU operation codes and operand forwarding selects
 */
package corePipePkg;

  // ALU operations carried from Q101 to Q102
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND
  } aluOpT;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FWD_NONE,  // Register file value from Q101
    FWD_MEM,   // ALU result sitting in Q103
    FWD_WB     // Write-back value in Q104
  } fwdSelT;

endpackage

// ==== hdl/coreTop.sv ====
/*
 * RV32I pipeline core
 * Fetch Q100, decode Q101, execute Q102, memory Q103, write-back Q104
 * Fixed-latency instruction and data memory ports, no back-pressure
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module coreTop (
  input  logic                   Clk,
  input  logic                   arstN,
  output logic [`CORE_XLEN-1:0]  pcQ100,          // To instruction memory
  input  logic [`CORE_XLEN-1:0]  instrQ101,       // Word at last pcQ100
  output logic [`CORE_XLEN-1:0]  dMemAddrQ103,
  output logic [`CORE_XLEN-1:0]  dMemWrDataQ103,
  output logic                   dMemWrEnQ103,
  output logic                   dMemRdEnQ103,
  input  logic [`CORE_XLEN-1:0]  dMemRdDataQ104   // One cycle after read enable
);

  rvIsaPkg::instrU             instrDecQ101;  // After bubble or replay
  logic                        pcEn;
  corePipePkg::aluOpT          aluOpQ101, aluOpQ102;
  corePipePkg::fwdSelT         fwdSel1Q102, fwdSel2Q102;
  logic                        selImmQ101, selImmQ102;
  logic                        isLuiQ101, isLuiQ102;
  logic                        isLoadQ101, isLoadQ102, isLoadQ103, isLoadQ104;
  logic                        isStoreQ101, isStoreQ102, isStoreQ103;
  logic                        regWrEnQ101, regWrEnQ102, regWrEnQ103, regWrEnQ104;
  logic [`CORE_REG_ADDR_W-1:0] rs1Q101, rs1Q102, rs2Q101, rs2Q102;
  logic [`CORE_REG_ADDR_W-1:0] rdQ101, rdQ102, rdQ103, rdQ104;
  logic [`CORE_XLEN-1:0]       immQ101, immQ102;
  logic [`CORE_XLEN-1:0]       regData1Q101, regData1Q102, regData2Q101, regData2Q102;
  logic [`CORE_XLEN-1:0]       aluOutQ102, aluOutQ103, aluOutQ104;
  logic [`CORE_XLEN-1:0]       storeDataQ102, storeDataQ103;
  logic [`CORE_XLEN-1:0]       wbDataQ104;

  ////////////////////////////////////////
  // Q100 fetch
  ////////////////////////////////////////
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN)    pcQ100 <= `CORE_RESET_PC;
    else if (pcEn) pcQ100 <= pcQ100 + 'd4;  // Held during load-use stall
  end

  ////////////////////////////////////////
  // Q101 decode and register read
  ////////////////////////////////////////
  hazardControl uHazard (
    .Clk         (Clk),
    .arstN       (arstN),
    .instrRaw    (instrQ101),
    .rdQ102      (rdQ102),
    .loadQ102    (isLoadQ102),
    .rs1Q102     (rs1Q102),
    .rs2Q102     (rs2Q102),
    .rdQ103      (rdQ103),
    .rdQ104      (rdQ104),
    .regWrEnQ103 (regWrEnQ103),
    .regWrEnQ104 (regWrEnQ104),
    .instrQ101   (instrDecQ101),
    .pcEn        (pcEn),
    .fwdSel1Q102 (fwdSel1Q102),
    .fwdSel2Q102 (fwdSel2Q102)
  );

  instrDecoder uDecoder (
    .instrQ101 (instrDecQ101),
    .aluOp     (aluOpQ101),
    .selImm    (selImmQ101),
    .isLoad    (isLoadQ101),
    .isStore   (isStoreQ101),
    .isLui     (isLuiQ101),
    .regWrEn   (regWrEnQ101),
    .rs1       (rs1Q101),
    .rs2       (rs2Q101),
    .rd        (rdQ101),
    .imm       (immQ101)
  );

  regFile uRegFile (
    .Clk     (Clk),
    .arstN   (arstN),
    .rdAddr1 (rs1Q101),
    .rdAddr2 (rs2Q101),
    .rdData1 (regData1Q101),
    .rdData2 (regData2Q101),
    .wrEn    (regWrEnQ104),  // Written from write-back
    .wrAddr  (rdQ104),
    .wrData  (wbDataQ104)
  );

  ////////////////////////////////////////
  // Q102 execute
  ////////////////////////////////////////
  execUnit uExec (
    .regData1Q102  (regData1Q102),
    .regData2Q102  (regData2Q102),
    .immQ102       (immQ102),
    .aluOutQ103    (aluOutQ103),
    .wbDataQ104    (wbDataQ104),
    .fwdSel1Q102   (fwdSel1Q102),
    .fwdSel2Q102   (fwdSel2Q102),
    .selImmQ102    (selImmQ102),
    .luiQ102       (isLuiQ102),
    .aluOpQ102     (aluOpQ102),
    .aluOutQ102    (aluOutQ102),
    .storeDataQ102 (storeDataQ102)
  );

  // Control pipe, cleared so nothing writes after reset
  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) begin
      aluOpQ102   <= corePipePkg::ADD;
      selImmQ102  <= 1'b0;
      isLuiQ102   <= 1'b0;
      isLoadQ102  <= 1'b0;
      isLoadQ103  <= 1'b0;
      isLoadQ104  <= 1'b0;
      isStoreQ102 <= 1'b0;
      isStoreQ103 <= 1'b0;
      regWrEnQ102 <= 1'b0;
      regWrEnQ103 <= 1'b0;
      regWrEnQ104 <= 1'b0;
    end else begin
      aluOpQ102   <= aluOpQ101;
      selImmQ102  <= selImmQ101;
      isLuiQ102   <= isLuiQ101;
      isLoadQ102  <= isLoadQ101;
      isLoadQ103  <= isLoadQ102;
      isLoadQ104  <= isLoadQ103;
      isStoreQ102 <= isStoreQ101;
      isStoreQ103 <= isStoreQ102;
      regWrEnQ102 <= regWrEnQ101;
      regWrEnQ103 <= regWrEnQ102;
      regWrEnQ104 <= regWrEnQ103;
    end
  end

  // Payload pipe
  always_ff @(posedge Clk) begin
    rs1Q102       <= rs1Q101;
    rs2Q102       <= rs2Q101;
    rdQ102        <= rdQ101;
    rdQ103        <= rdQ102;
    rdQ104        <= rdQ103;
    immQ102       <= immQ101;
    regData1Q102  <= regData1Q101;
    regData2Q102  <= regData2Q101;
    aluOutQ103    <= aluOutQ102;
    aluOutQ104    <= aluOutQ103;
    storeDataQ103 <= storeDataQ102;
  end

  ////////////////////////////////////////
  // Q103 memory, Q104 write-back
  ////////////////////////////////////////
  assign dMemAddrQ103   = aluOutQ103;
  assign dMemWrDataQ103 = storeDataQ103;
  assign dMemWrEnQ103   = isStoreQ103;  // SW only
  assign dMemRdEnQ103   = isLoadQ103;   // LW only

  assign wbDataQ104 = isLoadQ104 ? dMemRdDataQ104 : aluOutQ104;  // Load data or ALU

endmodule

// ==== hdl/core_settings.svh ====
/*
 * Core settings
 * Global widths and the reset PC of the RV32I pipeline
 */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data word and address width
`define CORE_XLEN       32
// Register index width
`define CORE_REG_ADDR_W 5
// Architectural registers, x0 included
`define CORE_REG_COUNT  32
// First fetch address
`define CORE_RESET_PC   32'h0000_0000

`endif

// ==== hdl/execUnit.sv ====
/*
 * Execute unit
 * Operand forwarding, immediate select and the RV32I ALU, all in Q102
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module execUnit (
  input  logic [`CORE_XLEN-1:0]  regData1Q102,
  input  logic [`CORE_XLEN-1:0]  regData2Q102,
  input  logic [`CORE_XLEN-1:0]  immQ102,
  input  logic [`CORE_XLEN-1:0]  aluOutQ103,
  input  logic [`CORE_XLEN-1:0]  wbDataQ104,
  input  corePipePkg::fwdSelT    fwdSel1Q102,
  input  corePipePkg::fwdSelT    fwdSel2Q102,
  input  logic                   selImmQ102,
  input  logic                   luiQ102,
  input  corePipePkg::aluOpT     aluOpQ102,
  output logic [`CORE_XLEN-1:0]  aluOutQ102,
  output logic [`CORE_XLEN-1:0]  storeDataQ102
);

  logic [`CORE_XLEN-1:0] opnd1;
  logic [`CORE_XLEN-1:0] opnd2Reg;  // rs2 after forwarding
  logic [`CORE_XLEN-1:0] opnd2;
  logic [4:0]            shamt;

  function automatic logic [`CORE_XLEN-1:0] fwdMux(
    input corePipePkg::fwdSelT    sel,
    input logic [`CORE_XLEN-1:0]  regVal,
    input logic [`CORE_XLEN-1:0]  memVal,
    input logic [`CORE_XLEN-1:0]  wbVal
  );
    case (sel)
      corePipePkg::FWD_MEM: return memVal;
      corePipePkg::FWD_WB:  return wbVal;
      default:              return regVal;
    endcase
  endfunction

  assign opnd1         = fwdMux(fwdSel1Q102, regData1Q102, aluOutQ103, wbDataQ104);
  assign opnd2Reg      = fwdMux(fwdSel2Q102, regData2Q102, aluOutQ103, wbDataQ104);
  assign storeDataQ102 = opnd2Reg;  // SW data
  assign opnd2         = selImmQ102 ? immQ102 : opnd2Reg;
  assign shamt         = opnd2[4:0];

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////
  always_comb begin
    case (aluOpQ102)
      corePipePkg::SUB:  aluOutQ102 = opnd1 - opnd2;
      corePipePkg::SLL:  aluOutQ102 = opnd1 << shamt;
      corePipePkg::SLT:  aluOutQ102 = {{(`CORE_XLEN-1){1'b0}}, $signed(opnd1) < $signed(opnd2)};
      corePipePkg::SLTU: aluOutQ102 = {{(`CORE_XLEN-1){1'b0}}, opnd1 < opnd2};
      corePipePkg::XOR:  aluOutQ102 = opnd1 ^ opnd2;
      corePipePkg::SRL:  aluOutQ102 = opnd1 >> shamt;
      corePipePkg::SRA:  aluOutQ102 = $signed(opnd1) >>> shamt;  // Sign fill
      corePipePkg::OR:   aluOutQ102 = opnd1 | opnd2;
      corePipePkg::AND:  aluOutQ102 = opnd1 & opnd2;
      default:           aluOutQ102 = opnd1 + opnd2;  // ADD, LW/SW address
    endcase
    if (luiQ102) aluOutQ102 = immQ102;  // U immediate straight through
  end

endmodule

// ==== hdl/hazardControl.sv ====
/*
 * Hazard control
 * Load-use stall with a one-cycle bubble and replay of the held word,
 * plus forwarding selects for both execute operands
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module hazardControl (
  input  logic                         Clk,
  input  logic                         arstN,
  input  rvIsaPkg::instrU              instrRaw,
  input  logic [`CORE_REG_ADDR_W-1:0]  rdQ102,
  input  logic                         loadQ102,
  input  logic [`CORE_REG_ADDR_W-1:0]  rs1Q102,
  input  logic [`CORE_REG_ADDR_W-1:0]  rs2Q102,
  input  logic [`CORE_REG_ADDR_W-1:0]  rdQ103,
  input  logic [`CORE_REG_ADDR_W-1:0]  rdQ104,
  input  logic                         regWrEnQ103,
  input  logic                         regWrEnQ104,
  output rvIsaPkg::instrU              instrQ101,
  output logic                         pcEn,
  output corePipePkg::fwdSelT          fwdSel1Q102,
  output corePipePkg::fwdSelT          fwdSel2Q102
);

  logic            loadUse;
  logic            replayQ;    // Held word goes to decode now
  rvIsaPkg::instrU heldInstr;  // Word hidden under the bubble

  // Youngest writer wins, x0 always reads zero
  function automatic corePipePkg::fwdSelT pickSrc(
    input logic [`CORE_REG_ADDR_W-1:0] rs,
    input logic [`CORE_REG_ADDR_W-1:0] rdMem,
    input logic                        wrEnMem,
    input logic [`CORE_REG_ADDR_W-1:0] rdWb,
    input logic                        wrEnWb
  );
    if (rs == '0) return corePipePkg::FWD_NONE;
    if (wrEnMem && (rs == rdMem)) return corePipePkg::FWD_MEM;
    if (wrEnWb && (rs == rdWb)) return corePipePkg::FWD_WB;
    return corePipePkg::FWD_NONE;
  endfunction

  ////////////////////////////////////////
  // Load-use stall and replay
  ////////////////////////////////////////
  assign loadUse = loadQ102 && (rdQ102 != '0) &&
                   ((instrRaw.rType.rs1 == rdQ102) || (instrRaw.rType.rs2 == rdQ102));
  assign pcEn    = !loadUse;  // Fetch holds one cycle

  assign instrQ101 = loadUse ? rvIsaPkg::instrU'(rvIsaPkg::nopInstr) :
                     replayQ ? heldInstr : instrRaw;

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN) replayQ <= 1'b0;
    else        replayQ <= loadUse;
  end

  always_ff @(posedge Clk) begin
    heldInstr <= instrRaw;  // Memory moves on to the next PC meanwhile
  end

  // Forwarding into Q102
  assign fwdSel1Q102 = pickSrc(rs1Q102, rdQ103, regWrEnQ103, rdQ104, regWrEnQ104);
  assign fwdSel2Q102 = pickSrc(rs2Q102, rdQ103, regWrEnQ103, rdQ104, regWrEnQ104);

endmodule

// ==== hdl/instrDecoder.sv ====
/*
 * Instruction decoder
 * Turns the Q101 instruction into control bits, register indices
 * and a sign-extended I, S or U immediate
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module instrDecoder (
  input  rvIsaPkg::instrU              instrQ101,
  output corePipePkg::aluOpT           aluOp,
  output logic                         selImm,
  output logic                         isLoad,
  output logic                         isStore,
  output logic                         isLui,
  output logic                         regWrEn,
  output logic [`CORE_REG_ADDR_W-1:0]  rs1,
  output logic [`CORE_REG_ADDR_W-1:0]  rs2,
  output logic [`CORE_REG_ADDR_W-1:0]  rd,
  output logic [`CORE_XLEN-1:0]        imm
);

  rvIsaPkg::opcodeT opcode;
  logic [2:0]       funct3;
  logic             altOp;  // funct7 asks for SUB or SRA
  logic             isRop;
  logic             isIop;

  assign opcode = rvIsaPkg::opcodeT'(instrQ101.iType.opcode);
  assign funct3 = instrQ101.iType.funct3;
  assign altOp  = (instrQ101.rType.funct7 == rvIsaPkg::funct7Alt);
  assign isRop  = (opcode == rvIsaPkg::R_OP);
  assign isIop  = (opcode == rvIsaPkg::I_OP);

  // Register indices
  assign rs1 = instrQ101.iType.rs1;
  assign rs2 = instrQ101.rType.rs2;
  assign rd  = instrQ101.iType.rd;

  // Control bits
  assign isLoad  = (opcode == rvIsaPkg::LOAD);
  assign isStore = (opcode == rvIsaPkg::STORE);
  assign isLui   = (opcode == rvIsaPkg::LUI);
  assign selImm  = isIop | isLoad | isStore | isLui;
  assign regWrEn = isRop | isIop | isLoad | isLui;  // Unknown opcode writes nothing

  always_comb begin
    aluOp = corePipePkg::ADD;  // LW/SW address, don't care for LUI
    if (isRop || isIop) begin
      case (funct3)
        3'b000: if (isRop && altOp) aluOp = corePipePkg::SUB;  // No SUBI
        3'b001: aluOp = corePipePkg::SLL;
        3'b010: aluOp = corePipePkg::SLT;
        3'b011: aluOp = corePipePkg::SLTU;
        3'b100: aluOp = corePipePkg::XOR;
        3'b101: aluOp = altOp ? corePipePkg::SRA : corePipePkg::SRL;  // SRAI too
        3'b110: aluOp = corePipePkg::OR;
        default: aluOp = corePipePkg::AND;
      endcase
    end
  end

  // Immediate generator
  always_comb begin
    case (opcode)
      rvIsaPkg::STORE: imm = {{(`CORE_XLEN-12){instrQ101.sType.immHi[6]}},
                              instrQ101.sType.immHi, instrQ101.sType.immLo};
      rvIsaPkg::LUI:   imm = {instrQ101.iType.imm12, instrQ101.iType.rs1,
                              instrQ101.iType.funct3, 12'b0};
      default:         imm = {{(`CORE_XLEN-12){instrQ101.iType.imm12[11]}},
                              instrQ101.iType.imm12};  // I type
    endcase
  end

endmodule

// ==== hdl/regFile.sv ====
/*
 * Register file
 * 31 writable registers, x0 hardwired to zero,
 * combinational reads with same-cycle write-through
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module regFile (
  input  logic                         Clk,
  input  logic                         arstN,
  input  logic [`CORE_REG_ADDR_W-1:0]  rdAddr1,
  input  logic [`CORE_REG_ADDR_W-1:0]  rdAddr2,
  output logic [`CORE_XLEN-1:0]        rdData1,
  output logic [`CORE_XLEN-1:0]        rdData2,
  input  logic                         wrEn,
  input  logic [`CORE_REG_ADDR_W-1:0]  wrAddr,
  input  logic [`CORE_XLEN-1:0]        wrData
);

  logic [`CORE_REG_COUNT-1:1][`CORE_XLEN-1:0] regs;  // No storage for x0
  logic                                      wrLive;

  assign wrLive = wrEn && (wrAddr != '0);  // Writes to x0 dropped

  always_ff @(posedge Clk or negedge arstN) begin
    if (!arstN)      regs         <= '0;
    else if (wrLive) regs[wrAddr] <= wrData;
  end

  // Q104 write seen by Q101 read in the same cycle
  assign rdData1 = (rdAddr1 == '0)                 ? '0     :
                   (wrLive && (wrAddr == rdAddr1)) ? wrData : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0)                 ? '0     :
                   (wrLive && (wrAddr == rdAddr2)) ? wrData : regs[rdAddr2];

endmodule

// ==== hdl/rvIsaPkg.sv ====
/*
 * RV32I instruction set package
 * Opcodes, funct constants and the three views of an instruction word
 */
package rvIsaPkg;

  // Major opcodes kept by this core
  typedef enum logic [6:0] {
    R_OP  = 7'b0110011,
    I_OP  = 7'b0010011,
    LOAD  = 7'b0000011,
    STORE = 7'b0100011,
    LUI   = 7'b0110111
  } opcodeT;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;  // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;  // imm[4:0]
    logic [6:0] opcode;
  } sTypeT;

  // One word, three decodings
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    sTypeT sType;
  } instrU;

  localparam logic [6:0]  funct7Alt = 7'b0100000;     // SUB and SRA
  localparam logic [31:0] nopInstr  = 32'h0000_0013;  // ADDI x0, x0, 0

endpackage

// ==== test/coreTb.sv ====
/*
 * Core testbench
 * Instruction and data memory models around coreTop, directed tests for
 * ALU ops, immediates, load-use stall and x0, checked through the stores
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module coreTb;

  localparam int         MemWords = 1024;
  localparam int         RunLimit = 400;          // Cycles allowed per program
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  // {alt, funct3}: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND, index 0 first
  localparam logic [9:0][3:0] ROps = {4'h7, 4'h6, 4'hD, 4'h5, 4'h4,
                                      4'h3, 4'h2, 4'h1, 4'h8, 4'h0};
  // funct3: ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI, index 0 first
  localparam logic [8:0][2:0] IF3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6,
                                     3'd4, 3'd3, 3'd2, 3'd0};

  logic                  Clk = 1'b0;
  logic                  arstN;
  logic [`CORE_XLEN-1:0] pcQ100;
  logic [`CORE_XLEN-1:0] instrQ101 = rvIsaPkg::nopInstr;
  logic [`CORE_XLEN-1:0] dMemAddrQ103;
  logic [`CORE_XLEN-1:0] dMemWrDataQ103;
  logic                  dMemWrEnQ103;
  logic                  dMemRdEnQ103;
  logic [`CORE_XLEN-1:0] dMemRdDataQ104 = '0;

  logic [31:0] imem [MemWords];
  logic [31:0] dmem [MemWords];
  logic [31:0] stAddr[$];   // Every store seen on the port
  logic [31:0] stData[$];
  logic [31:0] prog[$];     // Program under construction
  logic [31:0] expAddr[$];
  logic [31:0] expData[$];
  int          errCount;
  int          seed;

  always #20 Clk = ~Clk;

  coreTop DUT (
    .Clk            (Clk),
    .arstN          (arstN),
    .pcQ100         (pcQ100),
    .instrQ101      (instrQ101),
    .dMemAddrQ103   (dMemAddrQ103),
    .dMemWrDataQ103 (dMemWrDataQ103),
    .dMemWrEnQ103   (dMemWrEnQ103),
    .dMemRdEnQ103   (dMemRdEnQ103),
    .dMemRdDataQ104 (dMemRdDataQ104)
  );

  ////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////
  always @(posedge Clk) begin
    if (!arstN) instrQ101 <= rvIsaPkg::nopInstr;  // Bubble while in reset
    else        instrQ101 <= imem[pcQ100[11:2]];  // Registered fetch
  end

  always @(posedge Clk) begin
    if (dMemWrEnQ103) begin
      dmem[dMemAddrQ103[11:2]] <= dMemWrDataQ103;
      stAddr.push_back(dMemAddrQ103);
      stData.push_back(dMemWrDataQ103);
    end
    if (dMemRdEnQ103) dMemRdDataQ104 <= dmem[dMemAddrQ103[11:2]];  // Next cycle
  end

  ////////////////////////////////////////
  // Encoders and reference
  ////////////////////////////////////////
  function automatic logic [31:0] rWord(input logic [2:0] f3, input logic alt,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iWord(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sWord(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};  // SW, base x0
  endfunction

  function automatic logic [31:0] uWord(input logic [4:0] rd, input logic [19:0] imm20);
    return {imm20, rd, 7'b0110111};
  endfunction

  // RV32I result by funct3 and the alternate funct7 bit
  function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'd0;  // Sign bits for SRA
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? ((a >> sh) | fill) : (a >> sh);
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic compareVal(input string sig, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      errCount++;
      $display("** Error: %s got %h expected %h", sig, got, exp);
    end
  endtask

  // LUI + ADDI, upper part rounded for the sign-extended low part
  task automatic loadConst(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] upper;
    upper = val + 32'h800;
    prog.push_back(uWord(rd, upper[31:12]));
    prog.push_back(iWord(OpImm, 3'd0, rd, rd, val[11:0]));
  endtask

  task automatic storeWord(input logic [4:0] rs2, input logic [11:0] off,
                           input logic [31:0] val);
    prog.push_back(sWord(rs2, off));
    expAddr.push_back({20'd0, off});
    expData.push_back(val);
  endtask

  task automatic holdReset();
    @(posedge Clk);
    arstN <= 1'b0;
    repeat (10) @(posedge Clk);
  endtask

  // Load prog, release reset, wait for the expected stores and compare in order
  task automatic runProgram(input string name);
    int base;
    int cycles;
    holdReset();
    foreach (imem[i]) imem[i] = iWord(OpImm, 3'd0, 5'd0, 5'd0, 12'(i));  // x0 filler
    foreach (prog[i]) imem[i] = prog[i];
    base   = stAddr.size();
    cycles = 0;
    arstN <= 1'b1;
    while ((stAddr.size() < base + expAddr.size()) && (cycles < RunLimit)) begin
      @(posedge Clk);
      cycles++;
    end
    if (stAddr.size() < base + expAddr.size()) begin
      errCount++;
      $display("Timeout in %s test: %0d of %0d stores seen after %0d cycles",
               name, stAddr.size() - base, expAddr.size(), cycles);
    end
    repeat (8) @(posedge Clk);  // Room for a stray store
    compareVal("storeCount", stAddr.size() - base, expAddr.size());
    for (int i = 0; (i < expAddr.size()) && (base + i < stAddr.size()); i++) begin
      compareVal("dMemAddrQ103", stAddr[base+i], expAddr[i]);
      compareVal("dMemWrDataQ103", stData[base+i], expData[i]);
    end
    prog.delete();
    expAddr.delete();
    expData.delete();
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic resetValues();
    holdReset();
    compareVal("pcQ100", pcQ100, `CORE_RESET_PC);
    compareVal("dMemWrEnQ103", {31'd0, dMemWrEnQ103}, 32'd0);
    compareVal("dMemRdEnQ103", {31'd0, dMemRdEnQ103}, 32'd0);
  endtask

  task automatic regRegOps();
    logic [31:0] a;
    logic [31:0] b;
    logic [3:0]  op;
    for (int round = 0; round < 2; round++) begin
      a = $random(seed);
      b = $random(seed);
      loadConst(5'd1, a);
      loadConst(5'd2, b);
      for (int i = 0; i < 10; i++) begin
        op = ROps[i];
        prog.push_back(rWord(op[2:0], op[3], 5'(3 + i), 5'd1, 5'd2));
        repeat (i % 3) prog.push_back(rvIsaPkg::nopInstr);  // Distance 1, 2 or 3
        storeWord(5'(3 + i), 12'(256 + 4 * i), aluModel(op[2:0], op[3], a, b));
      end
      runProgram("R-type");
    end
  endtask

  task automatic immOps();
    logic [31:0] a;
    logic [11:0] imm;
    logic [19:0] upper;
    a = $random(seed);
    loadConst(5'd1, a);
    for (int i = 0; i < 9; i++) begin
      imm = 12'($random(seed));
      if (i < 6) imm[11] = i[0];  // Alternate sign
      else       imm = {(i == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};  // Shift amount
      prog.push_back(iWord(OpImm, IF3[i], 5'(10 + i), 5'd1, imm));
      storeWord(5'(10 + i), 12'(384 + 4 * i),
                aluModel(IF3[i], i == 8, a, {{20{imm[11]}}, imm}));
    end
    for (int j = 0; j < 2; j++) begin
      upper     = 20'($random(seed));
      upper[19] = j[0];
      prog.push_back(uWord(5'(20 + j), upper));
      storeWord(5'(20 + j), 12'(448 + 4 * j), {upper, 12'd0});
    end
    runProgram("I-type");
  endtask

  task automatic loadUseStall();
    logic [31:0] val;
    logic [31:0] addend;
    val    = $random(seed);
    addend = $random(seed);
    loadConst(5'd5, val);
    loadConst(5'd6, addend);
    storeWord(5'd5, 12'h200, val);
    prog.push_back(iWord(OpLoad, 3'b010, 5'd7, 5'd0, 12'h200));
    prog.push_back(rWord(3'd0, 1'b0, 5'd8, 5'd7, 5'd6));  // Needs x7 at once
    storeWord(5'd8, 12'h204, val + addend);
    prog.push_back(iWord(OpLoad, 3'b010, 5'd9, 5'd0, 12'h200));
    storeWord(5'd9, 12'h208, val);  // Load into store data
    runProgram("load-use");
  endtask

  task automatic zeroRegister();
    loadConst(5'd11, 32'h5A5A_0F0F);
    prog.push_back(iWord(OpImm, 3'd0, 5'd0, 5'd0, 12'h7FF));  // Dropped write
    storeWord(5'd0, 12'h300, 32'd0);
    prog.push_back(uWord(5'd0, 20'hABCDE));
    prog.push_back(rvIsaPkg::nopInstr);
    storeWord(5'd0, 12'h304, 32'd0);
    prog.push_back(rWord(3'd0, 1'b0, 5'd11, 5'd0, 5'd0));
    storeWord(5'd11, 12'h308, 32'd0);
    runProgram("x0");
  endtask

  initial begin
    seed     = 77889;
    errCount = 0;
    arstN    = 1'b0;
    resetValues();
    regRegOps();
    immOps();
    loadUseStall();
    zeroRegister();
    $display("Checks finished with %0d errors", errCount);
    if (errCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== test/coreTb_sva.sv ====
/*
 * Core port assertions
 * Bound into coreTop: data memory enables exclusive and quiet in reset,
 * PC either holds or steps one word
 */
`timescale 1ns/10ps
`include "core_settings.svh"

module coreSva (
  input logic                  Clk,
  input logic                  arstN,
  input logic [`CORE_XLEN-1:0] pcQ100,
  input logic                  dMemWrEnQ103,
  input logic                  dMemRdEnQ103
);

  // One data access per cycle
  memExclusive: assert property (@(posedge Clk) !(dMemWrEnQ103 && dMemRdEnQ103))
    else $error("data memory read and write enables high together");

  // Hold on load-use stall, else next word
  pcStep: assert property (@(posedge Clk) disable iff (!arstN)
    (pcQ100 == $past(pcQ100)) || (pcQ100 == $past(pcQ100) + 32'd4))
    else $error("pcQ100 neither held nor advanced by 4");

  quietInReset: assert property (@(posedge Clk)
    !arstN |-> !(dMemWrEnQ103 || dMemRdEnQ103))
    else $error("data memory enable high during reset");

endmodule

bind coreTop coreSva uSva (
  .Clk          (Clk),
  .arstN        (arstN),
  .pcQ100       (pcQ100),
  .dMemWrEnQ103 (dMemWrEnQ103),
  .dMemRdEnQ103 (dMemRdEnQ103)
);
